//--- axi_lite_read_mux.f
design/axi_lite_mux_pkg.sv
design/read_order_if.sv
design/ar_rr_arbiter.sv
design/read_order_fifo.sv
design/ar_spill_reg.sv
design/r_resp_router.sv
design/axi_lite_read_mux.sv
verif/axi_lite_read_mux_tb.sv

//--- verif/axi_lite_read_mux_tb.sv
`timescale 1ns/1ps

module axi_lite_read_mux_tb import axi_lite_mux_pkg::*; ();

  // About four times the length of all tests
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int          NO_LIMIT       = 1 << 30;

  logic                             clk_i;
  logic                             rst_n_i;
  logic [NUM_PORTS-1:0]             slv_ar_valid_i;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] slv_ar_addr_i;
  logic [NUM_PORTS-1:0][PROT_W-1:0] slv_ar_prot_i;
  logic [NUM_PORTS-1:0]             slv_ar_ready_o;
  logic [NUM_PORTS-1:0]             slv_r_valid_o;
  logic [NUM_PORTS-1:0][DATA_W-1:0] slv_r_data_o;
  logic [NUM_PORTS-1:0][RESP_W-1:0] slv_r_resp_o;
  logic [NUM_PORTS-1:0]             slv_r_ready_i;
  logic                             mst_ar_valid_o;
  logic [ADDR_W-1:0]                mst_ar_addr_o;
  logic [PROT_W-1:0]                mst_ar_prot_o;
  logic                             mst_ar_ready_i;
  logic                             mst_r_valid_i;
  logic [DATA_W-1:0]                mst_r_data_i;
  logic [RESP_W-1:0]                mst_r_resp_i;
  logic                             mst_r_ready_o;

  // Scoreboard, port side, master side and returned beats
  int                port_q[$];
  logic [ADDR_W-1:0] port_addr_q[$];
  logic [PROT_W-1:0] port_prot_q[$];
  logic [ADDR_W-1:0] mst_addr_q[$];
  logic [PROT_W-1:0] mst_prot_q[$];
  int                rx_port_q[$];
  logic [DATA_W-1:0] rx_data_q[$];
  logic [RESP_W-1:0] rx_resp_q[$];

  logic [NUM_PORTS-1:0] acc_last;
  logic [NUM_PORTS-1:0] req_hold;
  logic [NUM_PORTS-1:0] exp_valid;
  logic                 exp_ready;
  int                   rx_port;
  int                   r_allow;
  int                   ar_chk;
  int                   r_chk;
  int                   cycles;
  int                   errors;
  int                   seed_val;
  string                test_name;

  axi_lite_read_mux axi_lite_read_mux_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Master returns a word derived from the read address
  function automatic logic [DATA_W-1:0] beat_data(input logic [ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h0bad_f00d;
  endfunction

  task automatic log_mismatch(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
    $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
    errors++;
  endtask

  // --------------------
  // Monitor
  // --------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Expected routing from the port issue order
      exp_valid = '0;
      exp_ready = 1'b0;
      if (rx_port_q.size() < port_q.size()) begin
        exp_valid = NUM_PORTS'(mst_r_valid_i) << port_q[rx_port_q.size()];
        exp_ready = slv_r_ready_i[port_q[rx_port_q.size()]];
      end
      if (slv_r_valid_o !== exp_valid)
        log_mismatch("slv_r_valid_o", exp_valid, slv_r_valid_o);
      if (mst_r_ready_o !== exp_ready) log_mismatch("mst_r_ready_o", exp_ready, mst_r_ready_o);
      if (mst_r_valid_i && mst_r_ready_o) begin
        rx_port = -1;
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (slv_r_valid_o[p] && slv_r_ready_i[p]) rx_port = p;
        end
        rx_port_q.push_back(rx_port);
        rx_data_q.push_back(rx_port < 0 ? '0 : slv_r_data_o[rx_port]);
        rx_resp_q.push_back(rx_port < 0 ? '0 : slv_r_resp_o[rx_port]);
      end
      acc_last = slv_ar_valid_i & slv_ar_ready_o;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (acc_last[p]) begin
          port_q.push_back(p);
          port_addr_q.push_back(slv_ar_addr_i[p]);
          port_prot_q.push_back(slv_ar_prot_i[p]);
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        mst_addr_q.push_back(mst_ar_addr_o);
        mst_prot_q.push_back(mst_ar_prot_o);
      end
    end
  end

  // Master R model, one beat per recorded AR, in order
  task automatic drive_master_r();
    int idx;
    idx = rx_port_q.size();
    mst_r_valid_i = (idx < mst_addr_q.size()) && (idx < r_allow);
    if (mst_r_valid_i) begin
      mst_r_data_i = beat_data(mst_addr_q[idx]);
      mst_r_resp_i = mst_addr_q[idx][1:0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    // Taken requests drop, held ones come back with a new address
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (acc_last[p]) begin
        slv_ar_addr_i[p] = $urandom;
        slv_ar_prot_i[p] = PROT_W'($urandom);
      end
    end
    slv_ar_valid_i = (slv_ar_valid_i & ~acc_last) | req_hold;
    drive_master_r();
  endtask

  task automatic issue_read(input int p, input logic [ADDR_W-1:0] addr,
                            input logic [PROT_W-1:0] prot);
    slv_ar_addr_i[p]  = addr;
    slv_ar_prot_i[p]  = prot;
    slv_ar_valid_i[p] = 1'b1;
    do next_cycle(); while (!acc_last[p]);
  endtask

  // Master side and returned beats against the port issue order
  task automatic check_order();
    while (ar_chk < mst_addr_q.size()) begin
      if (mst_addr_q[ar_chk] !== port_addr_q[ar_chk])
        log_mismatch("mst_ar_addr_o", port_addr_q[ar_chk], mst_addr_q[ar_chk]);
      if (mst_prot_q[ar_chk] !== port_prot_q[ar_chk])
        log_mismatch("mst_ar_prot_o", port_prot_q[ar_chk], mst_prot_q[ar_chk]);
      ar_chk++;
    end
    while (r_chk < rx_port_q.size()) begin
      if (rx_port_q[r_chk] != port_q[r_chk])
        log_mismatch("R port", port_q[r_chk], rx_port_q[r_chk]);
      if (rx_data_q[r_chk] !== beat_data(port_addr_q[r_chk]))
        log_mismatch("R data", beat_data(port_addr_q[r_chk]), rx_data_q[r_chk]);
      if (rx_resp_q[r_chk] !== port_addr_q[r_chk][1:0])
        log_mismatch("R resp", port_addr_q[r_chk][1:0], rx_resp_q[r_chk]);
      r_chk++;
    end
  endtask

  // Let every request and every beat complete
  task automatic drain();
    req_hold       = '0;
    r_allow        = NO_LIMIT;
    mst_ar_ready_i = 1'b1;
    slv_r_ready_i  = '1;
    do next_cycle();
    while (slv_ar_valid_i != '0 || mst_addr_q.size() != port_q.size() ||
           rx_port_q.size() != port_q.size());
    check_order();
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic single_read();
    logic [ADDR_W-1:0] addr;
    logic [PROT_W-1:0] prot;
    test_name = "single_read";
    for (int p = 0; p < NUM_PORTS; p++) begin
      addr = $urandom;
      prot = PROT_W'($urandom);
      issue_read(p, addr, prot);
      // Spill register empty, so the AR is at the master one cycle later
      if (mst_ar_valid_o !== 1'b1) log_mismatch("mst_ar_valid_o", 1, mst_ar_valid_o);
      drain();
      if (mst_addr_q[mst_addr_q.size()-1] !== addr)
        log_mismatch("mst_ar_addr_o", addr, mst_addr_q[mst_addr_q.size()-1]);
      if (mst_prot_q[mst_prot_q.size()-1] !== prot)
        log_mismatch("mst_ar_prot_o", prot, mst_prot_q[mst_prot_q.size()-1]);
      if (rx_port_q[rx_port_q.size()-1] != p)
        log_mismatch("R port", p, rx_port_q[rx_port_q.size()-1]);
    end
  endtask

  // Last grant was port 3, so the order restarts at port 0
  task automatic round_robin();
    int base;
    test_name = "round_robin";
    base      = port_q.size();
    req_hold  = '1;
    do next_cycle(); while (port_q.size() < base + 2 * NUM_PORTS);
    drain();
    for (int k = 0; k < 2 * NUM_PORTS; k++) begin
      if (port_q[base + k] != k % NUM_PORTS)
        log_mismatch("grant", k % NUM_PORTS, port_q[base + k]);
    end
  endtask

  task automatic in_order_return();
    test_name = "in_order_return";
    r_allow   = rx_port_q.size();
    for (int k = 0; k < 6; k++) begin
      // Release the held beats halfway
      if (k == 3) r_allow = NO_LIMIT;
      issue_read((k * 3 + 2) % NUM_PORTS, $urandom, PROT_W'($urandom));
    end
    drain();
  endtask

  task automatic outstanding_limit();
    int base;
    test_name = "outstanding_limit";
    base      = port_q.size();
    r_allow   = rx_port_q.size();
    req_hold  = '1;
    repeat (20) next_cycle();
    if (port_q.size() - base != MAX_TRANS)
      log_mismatch("AR count", MAX_TRANS, port_q.size() - base);
    r_allow = rx_port_q.size() + 1;
    do next_cycle(); while (rx_port_q.size() < r_allow);
    repeat (10) next_cycle();
    if (port_q.size() - base != MAX_TRANS + 1)
      log_mismatch("AR count", MAX_TRANS + 1, port_q.size() - base);
    drain();
  endtask

  task automatic backpressure();
    int base;
    int head;
    test_name      = "backpressure";
    base           = port_q.size();
    r_allow        = base;
    mst_ar_ready_i = 1'b0;
    slv_ar_valid_i = 4'b1110;
    repeat (10) next_cycle();
    if (port_q.size() - base != 2) log_mismatch("AR count", 2, port_q.size() - base);
    if (mst_addr_q.size() != base) log_mismatch("mst AR count", base, mst_addr_q.size());
    mst_ar_ready_i = 1'b1;
    do next_cycle(); while (mst_addr_q.size() < base + 3);
    check_order();
    // Head port stalls its R channel
    head          = port_q[base];
    slv_r_ready_i = ~(NUM_PORTS'(1) << head);
    r_allow       = base + 1;
    repeat (5) next_cycle();
    if (rx_port_q.size() != base) log_mismatch("R count", base, rx_port_q.size());
    if (mst_r_ready_o !== 1'b0) log_mismatch("mst_r_ready_o", 0, mst_r_ready_o);
    if (slv_r_valid_o[head] !== 1'b1) log_mismatch("slv_r_valid_o", 1, slv_r_valid_o[head]);
    slv_r_ready_i = '1;
    do next_cycle(); while (rx_port_q.size() == base);
    drain();
  endtask

  initial begin
    seed_val       = $urandom(32'h1aeb);
    rst_n_i        = 1'b0;
    slv_ar_valid_i = '0;
    slv_ar_addr_i  = '0;
    slv_ar_prot_i  = '0;
    slv_r_ready_i  = '1;
    mst_ar_ready_i = 1'b1;
    mst_r_valid_i  = 1'b0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    acc_last       = '0;
    req_hold       = '0;
    r_allow        = NO_LIMIT;
    test_name      = "reset";
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    if (slv_ar_ready_o !== '0) log_mismatch("slv_ar_ready_o", 0, slv_ar_ready_o);
    if (mst_ar_valid_o !== 1'b0) log_mismatch("mst_ar_valid_o", 0, mst_ar_valid_o);
    if (slv_r_valid_o !== '0) log_mismatch("slv_r_valid_o", 0, slv_r_valid_o);
    if (mst_r_ready_o !== 1'b0) log_mismatch("mst_r_ready_o", 0, mst_r_ready_o);
    single_read();
    round_robin();
    in_order_return();
    outstanding_limit();
    backpressure();
    $display("Checks failed: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- design/axi_lite_read_mux.sv
`timescale 1ns/1ps

module axi_lite_read_mux import axi_lite_mux_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Upstream AR ports
  input  logic [NUM_PORTS-1:0]              slv_ar_valid_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0]  slv_ar_addr_i,
  input  logic [NUM_PORTS-1:0][PROT_W-1:0]  slv_ar_prot_i,
  output logic [NUM_PORTS-1:0]              slv_ar_ready_o,
  // Upstream R ports
  output logic [NUM_PORTS-1:0]              slv_r_valid_o,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]  slv_r_data_o,
  output logic [NUM_PORTS-1:0][RESP_W-1:0]  slv_r_resp_o,
  input  logic [NUM_PORTS-1:0]              slv_r_ready_i,
  // Master AR port
  output logic                              mst_ar_valid_o,
  output logic [ADDR_W-1:0]                 mst_ar_addr_o,
  output logic [PROT_W-1:0]                 mst_ar_prot_o,
  input  logic                              mst_ar_ready_i,
  // Master R port
  input  logic                              mst_r_valid_i,
  input  logic [DATA_W-1:0]                 mst_r_data_i,
  input  logic [RESP_W-1:0]                 mst_r_resp_i,
  output logic                              mst_r_ready_o
);

  // Per-port AR fields packed into channels
  ar_chan_t [NUM_PORTS-1:0] slv_ar_chan;

  // Arbiter to spill register
  logic     arb_valid;
  logic     arb_ready;
  ar_chan_t arb_chan;
  ar_chan_t mst_ar_chan;

  // R beats before and after routing
  r_chan_t  mst_r_chan;
  r_chan_t  slv_r_chan;

  // Issue order between AR and R
  read_order_if order_if ();

  // --------------------
  // Field packing
  // --------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port_fields
    assign slv_ar_chan[i].addr = slv_ar_addr_i[i];
    assign slv_ar_chan[i].prot = slv_ar_prot_i[i];
    assign slv_r_data_o[i]     = slv_r_chan.data;
    assign slv_r_resp_o[i]     = slv_r_chan.resp;
  end

  assign mst_ar_addr_o   = mst_ar_chan.addr;
  assign mst_ar_prot_o   = mst_ar_chan.prot;
  assign mst_r_chan.data = mst_r_data_i;
  assign mst_r_chan.resp = mst_r_resp_i;

  // --------------------
  // AR path
  // --------------------
  ar_rr_arbiter ar_rr_arbiter_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slv_ar_valid_i),
    .chan_i  (slv_ar_chan),
    .gnt_o   (slv_ar_ready_o),
    .valid_o (arb_valid),
    .chan_o  (arb_chan),
    .ready_i (arb_ready),
    .order   (order_if.issue)
  );

  ar_spill_reg ar_spill_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_chan),
    .valid_o (mst_ar_valid_o),
    .ready_i (mst_ar_ready_i),
    .data_o  (mst_ar_chan)
  );

  read_order_fifo read_order_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .order   (order_if.fifo)
  );

  // --------------------
  // R path
  // --------------------
  r_resp_router r_resp_router_i (
    .mst_valid_i (mst_r_valid_i),
    .mst_chan_i  (mst_r_chan),
    .mst_ready_o (mst_r_ready_o),
    .slv_valid_o (slv_r_valid_o),
    .slv_chan_o  (slv_r_chan),
    .slv_ready_i (slv_r_ready_i),
    .order       (order_if.ret)
  );

endmodule

//--- design/r_resp_router.sv
`timescale 1ns/1ps

module r_resp_router import axi_lite_mux_pkg::*; (
  // Master R channel
  input  logic                 mst_valid_i,
  input  r_chan_t              mst_chan_i,
  output logic                 mst_ready_o,
  // Upstream R ports
  output logic [NUM_PORTS-1:0] slv_valid_o,
  output r_chan_t              slv_chan_o,
  input  logic [NUM_PORTS-1:0] slv_ready_i,
  // Order FIFO pop side
  read_order_if.ret            order
);

  // Beat goes to all ports, valid only at the head port
  assign slv_chan_o = mst_chan_i;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_slv_valid
    assign slv_valid_o[i] = mst_valid_i & ~order.empty &
                            (order.head_sel == port_sel_t'(i));
  end

  // No beat accepted without an issued read
  assign mst_ready_o = ~order.empty & slv_ready_i[order.head_sel];

  // One beat retires one entry
  assign order.pop   = mst_valid_i & mst_ready_o;

endmodule

//--- design/ar_spill_reg.sv
`timescale 1ns/1ps

module ar_spill_reg import axi_lite_mux_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  ar_chan_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output ar_chan_t data_o
);

  // Slot A drives the output, slot B catches the overflow
  logic     a_full_q;
  logic     b_full_q;
  ar_chan_t a_data_q;
  ar_chan_t b_data_q;

  logic     in_xfer;
  logic     out_xfer;

  // Ready is a flop output only
  assign ready_o  = ~b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;

  assign in_xfer  = valid_i & ready_o;
  assign out_xfer = a_full_q & ready_i;

  // --------------------
  // Slot occupancy
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (b_full_q) begin
      // B moves up into A once A drains
      if (out_xfer) b_full_q <= 1'b0;
    end else if (in_xfer) begin
      // A busy and stalled, park in B
      if (a_full_q && !ready_i) b_full_q <= 1'b1;
      a_full_q <= 1'b1;
    end else if (out_xfer) begin
      a_full_q <= 1'b0;
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (b_full_q) begin
      if (out_xfer) a_data_q <= b_data_q;
    end else if (in_xfer) begin
      if (a_full_q && !ready_i) b_data_q <= data_i;
      else a_data_q <= data_i;
    end
  end

endmodule

//--- design/read_order_fifo.sv
`timescale 1ns/1ps

module read_order_fifo import axi_lite_mux_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  read_order_if.fifo  order
);

  // Issued port indices
  port_sel_t mem_q [MAX_TRANS];

  // Pointers and fill level
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;

  // Status from the fill count
  assign order.full     = (cnt_q == FIFO_CNT_W'(MAX_TRANS));
  assign order.empty    = (cnt_q == '0);
  assign order.head_sel = mem_q[rd_ptr_q];

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge clk_i) begin
    if (order.push) begin
      mem_q[wr_ptr_q] <= order.push_sel;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (order.push) begin
        // Wrap at the last entry
        if (wr_ptr_q == FIFO_PTR_W'(MAX_TRANS - 1)) wr_ptr_q <= '0;
        else wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (order.pop) begin
        if (rd_ptr_q == FIFO_PTR_W'(MAX_TRANS - 1)) rd_ptr_q <= '0;
        else rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level unchanged
      if (order.push && !order.pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (order.pop && !order.push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- design/ar_rr_arbiter.sv
`timescale 1ns/1ps

module ar_rr_arbiter import axi_lite_mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Upstream AR ports
  input  logic     [NUM_PORTS-1:0] req_i,
  input  ar_chan_t [NUM_PORTS-1:0] chan_i,
  output logic     [NUM_PORTS-1:0] gnt_o,
  // Toward the spill register
  output logic                     valid_o,
  output ar_chan_t                 chan_o,
  input  logic                     ready_i,
  // Order FIFO push side
  read_order_if.issue              order
);

  // Last granted port, start of the next search
  port_sel_t last_q;
  // Held decision while the output stalls
  logic      lock_q;
  port_sel_t lock_sel_q;

  // Round-robin pick
  port_sel_t rr_sel;
  logic      rr_found;

  // Final decision
  port_sel_t sel;
  logic      xfer;

  // --------------------
  // Round-robin search
  // --------------------
  always_comb begin
    rr_found = 1'b0;
    rr_sel   = last_q;
    // Scan from the port after the last grant, wrapping
    for (int unsigned i = 1; i <= NUM_PORTS; i++) begin
      if (!rr_found && req_i[(int'(last_q) + i) % NUM_PORTS]) begin
        rr_found = 1'b1;
        rr_sel   = port_sel_t'((int'(last_q) + i) % NUM_PORTS);
      end
    end
  end

  // Locked choice wins over a fresh search
  assign sel = lock_q ? lock_sel_q : rr_sel;

  // No issue while the order FIFO has no room
  assign valid_o = (lock_q | rr_found) & ~order.full;
  assign chan_o  = chan_i[sel];
  assign xfer    = valid_o & ready_i;

  // Ready back to the granted port only
  always_comb begin
    gnt_o = '0;
    if (xfer) begin
      gnt_o[sel] = 1'b1;
    end
  end

  // Record the issued index
  assign order.push     = xfer;
  assign order.push_sel = sel;

  // --------------------
  // Pointer and lock
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Port 0 comes first after reset
      last_q     <= port_sel_t'(NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      if (xfer) begin
        last_q <= sel;
        lock_q <= 1'b0;
      end else if (valid_o) begin
        // Stalled offer, keep it until taken
        lock_q     <= 1'b1;
        lock_sel_q <= sel;
      end
    end
  end

endmodule

//--- design/read_order_if.sv
`timescale 1ns/1ps

interface read_order_if import axi_lite_mux_pkg::*; ();

  // Issue side, one push per granted AR
  logic      push;
  port_sel_t push_sel;
  logic      full;

  // Return side, one pop per R beat
  logic      pop;
  port_sel_t head_sel;
  logic      empty;

  // AR arbiter
  modport issue (output push, output push_sel, input full);

  // Order FIFO
  modport fifo (
    input  push, input push_sel, input pop,
    output full, output head_sel, output empty
  );

  // R router
  modport ret (output pop, input head_sel, input empty);

endinterface

//--- design/axi_lite_mux_pkg.sv
package axi_lite_mux_pkg;

  // --------------------
  // Port count and depth
  // --------------------
  localparam int unsigned NUM_PORTS  = 4;
  // Reads in flight at most
  localparam int unsigned MAX_TRANS  = 4;

  // Channel field widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned PROT_W     = 3;
  localparam int unsigned RESP_W     = 2;

  // Derived widths
  localparam int unsigned SEL_W      = $clog2(NUM_PORTS);
  localparam int unsigned FIFO_CNT_W = $clog2(MAX_TRANS + 1);
  localparam int unsigned FIFO_PTR_W = $clog2(MAX_TRANS);

  // Upstream port index
  typedef logic [SEL_W-1:0] port_sel_t;

  // --------------------
  // Read channels
  // --------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [PROT_W-1:0] prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
  } r_chan_t;

endpackage
